// ==== src/alu_op_pkg.sv ====
package alu_op_pkg;

    localparam int CMD_W = 4;

    // arithmetic set, mode = 1
    localparam logic [CMD_W-1:0] OP_ADD     = 4'd0;
    localparam logic [CMD_W-1:0] OP_SUB     = 4'd1;
    localparam logic [CMD_W-1:0] OP_ADD_CIN = 4'd2;
    localparam logic [CMD_W-1:0] OP_SUB_CIN = 4'd3;
    localparam logic [CMD_W-1:0] OP_INC_A   = 4'd4;
    localparam logic [CMD_W-1:0] OP_DEC_A   = 4'd5;
    localparam logic [CMD_W-1:0] OP_INC_B   = 4'd6;
    localparam logic [CMD_W-1:0] OP_DEC_B   = 4'd7;
    localparam logic [CMD_W-1:0] OP_CMP     = 4'd8;
    localparam logic [CMD_W-1:0] OP_SADD    = 4'd9;
    localparam logic [CMD_W-1:0] OP_SSUB    = 4'd10; // 11..15 undefined

    // logic set, mode = 0
    localparam logic [CMD_W-1:0] OP_AND     = 4'd0;
    localparam logic [CMD_W-1:0] OP_NAND    = 4'd1;
    localparam logic [CMD_W-1:0] OP_OR      = 4'd2;
    localparam logic [CMD_W-1:0] OP_NOR     = 4'd3;
    localparam logic [CMD_W-1:0] OP_XOR     = 4'd4;
    localparam logic [CMD_W-1:0] OP_XNOR    = 4'd5;
    localparam logic [CMD_W-1:0] OP_NOT_A   = 4'd6;
    localparam logic [CMD_W-1:0] OP_NOT_B   = 4'd7;
    localparam logic [CMD_W-1:0] OP_SHR1_A  = 4'd8;
    localparam logic [CMD_W-1:0] OP_SHL1_A  = 4'd9;
    localparam logic [CMD_W-1:0] OP_SHR1_B  = 4'd10;
    localparam logic [CMD_W-1:0] OP_SHL1_B  = 4'd11;
    localparam logic [CMD_W-1:0] OP_ROL     = 4'd12;
    localparam logic [CMD_W-1:0] OP_ROR     = 4'd13; // 14, 15 undefined

    // one cmd word, read through the view that matches mode
    typedef union packed {
        logic [CMD_W-1:0] arith; // mode = 1
        logic [CMD_W-1:0] lgc;   // mode = 0
    } alu_cmd_u;

endpackage

// ==== src/alu_io_pkg.sv ====
package alu_io_pkg;

    // inp_valid must equal the set the opcode needs
    localparam logic [1:0] OPS_A  = 2'd1;
    localparam logic [1:0] OPS_B  = 2'd2;
    localparam logic [1:0] OPS_AB = 2'd3;

    localparam int FLAG_W = 8;

    // bit positions in the flags vector
    localparam int F_OFLOW = 0;
    localparam int F_COUT  = 1;
    localparam int F_G     = 2;
    localparam int F_L     = 3;
    localparam int F_E     = 4;
    localparam int F_ERR   = 5;
    localparam int F_NEG   = 6;
    localparam int F_ZERO  = 7;

endpackage

// ==== src/alu_stage_if.sv ====
`timescale 1ns/10ps

// issue register contents, shared by both units and writeback
interface alu_issue_if import alu_op_pkg::*; #(
    parameter int WIDTH = 8
);

    logic             valid;
    logic             mode;
    alu_cmd_u         cmd;
    logic [WIDTH-1:0] a;
    logic [WIDTH-1:0] b;
    logic             cin;
    logic             bad;   // operand mismatch or undefined opcode

    modport issue_mp (
        output valid, mode, cmd, a, b, cin, bad
    );

    modport exec_mp (
        input valid, mode, cmd, a, b, cin, bad
    );

endinterface

// unit result, one per execution unit
interface alu_result_if import alu_io_pkg::*; #(
    parameter int WIDTH = 8
);

    logic [WIDTH:0]    res;
    logic [FLAG_W-1:0] flags;

    modport unit_mp (
        output res, flags
    );

    modport wb_mp (
        input res, flags
    );

endinterface

// ==== src/alu_issue.sv ====
`timescale 1ns/10ps

module alu_issue import alu_op_pkg::*; import alu_io_pkg::*; #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ce,
    input  logic             mode,
    input  logic             cin,
    input  logic [1:0]       inp_valid,
    input  logic [CMD_W-1:0] cmd,
    input  logic [WIDTH-1:0] opa,
    input  logic [WIDTH-1:0] opb,
    alu_issue_if.issue_mp    iss
);

    alu_cmd_u   cmd_u;
    logic [1:0] need;   // operand set the opcode wants
    logic       known;

    assign cmd_u = cmd;

    always_comb begin
        need  = OPS_AB;
        known = 1'b1;
        if (mode) begin
            case (cmd_u.arith)
                OP_ADD, OP_SUB, OP_ADD_CIN, OP_SUB_CIN,
                OP_CMP, OP_SADD, OP_SSUB:  need = OPS_AB;
                OP_INC_A, OP_DEC_A:        need = OPS_A;
                OP_INC_B, OP_DEC_B:        need = OPS_B;
                default:                   known = 1'b0;
            endcase
        end else begin
            case (cmd_u.lgc)
                OP_AND, OP_NAND, OP_OR, OP_NOR, OP_XOR, OP_XNOR,
                OP_ROL, OP_ROR:                 need = OPS_AB;
                OP_NOT_A, OP_SHR1_A, OP_SHL1_A: need = OPS_A;
                OP_NOT_B, OP_SHR1_B, OP_SHL1_B: need = OPS_B;
                default:                        known = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iss.valid <= 1'b0;
            iss.mode  <= 1'b0;
            iss.cmd   <= '0;
            iss.a     <= '0;
            iss.b     <= '0;
            iss.cin   <= 1'b0;
            iss.bad   <= 1'b0;
        end else if (ce) begin
            iss.valid <= 1'b1;   // every enabled edge takes an item
            iss.mode  <= mode;
            iss.cmd   <= cmd_u;
            iss.a     <= opa;
            iss.b     <= opb;
            iss.cin   <= cin;
            iss.bad   <= !known || (inp_valid != need);
        end
    end

endmodule

// ==== src/alu_arith_unit.sv ====
`timescale 1ns/10ps

module alu_arith_unit import alu_op_pkg::*; import alu_io_pkg::*; #(
    parameter int WIDTH = 8
) (
    alu_issue_if.exec_mp  iss,
    alu_result_if.unit_mp rsl
);

    localparam logic [WIDTH:0] ONE = 1;

    logic [WIDTH:0] ea;
    logic [WIDTH:0] eb;
    logic [WIDTH:0] cin_x;
    logic [WIDTH:0] sum;
    logic [WIDTH:0] dif;
    logic           s_ovf_add;
    logic           s_ovf_sub;

    assign ea    = {1'b0, iss.a};
    assign eb    = {1'b0, iss.b};
    assign cin_x = {{WIDTH{1'b0}}, iss.cin};
    assign sum   = ea + eb;
    assign dif   = ea - eb;   // dif[WIDTH] is the borrow

    // signed overflow, sign of result differs from what the operands allow
    assign s_ovf_add = (iss.a[WIDTH-1] == iss.b[WIDTH-1]) && (sum[WIDTH-1] != iss.a[WIDTH-1]);
    assign s_ovf_sub = (iss.a[WIDTH-1] != iss.b[WIDTH-1]) && (dif[WIDTH-1] != iss.a[WIDTH-1]);

    always_comb begin
        rsl.res   = '0;
        rsl.flags = '0;
        case (iss.cmd.arith)
            OP_ADD:     rsl.res = sum;
            OP_SUB:     rsl.res = dif;
            OP_ADD_CIN: rsl.res = sum + cin_x;
            OP_SUB_CIN: rsl.res = dif - cin_x;
            OP_INC_A:   rsl.res = ea + ONE;
            OP_DEC_A:   rsl.res = ea - ONE;
            OP_INC_B:   rsl.res = eb + ONE;
            OP_DEC_B:   rsl.res = eb - ONE;
            OP_CMP: begin
                rsl.flags[F_G] = iss.a > iss.b;
                rsl.flags[F_L] = iss.a < iss.b;
                rsl.flags[F_E] = iss.a == iss.b;
            end
            OP_SADD: begin
                rsl.res              = {1'b0, sum[WIDTH-1:0]};
                rsl.flags[F_OFLOW]   = s_ovf_add;
                rsl.flags[F_COUT]    = sum[WIDTH];
                rsl.flags[F_NEG]     = sum[WIDTH-1];
                rsl.flags[F_ZERO]    = (sum[WIDTH-1:0] == '0);
            end
            OP_SSUB: begin
                rsl.res              = {1'b0, dif[WIDTH-1:0]};
                rsl.flags[F_OFLOW]   = s_ovf_sub;
                rsl.flags[F_COUT]    = dif[WIDTH];
                rsl.flags[F_NEG]     = dif[WIDTH-1];
                rsl.flags[F_ZERO]    = (dif[WIDTH-1:0] == '0);
            end
            default: ;   // undefined, issue already marked it bad
        endcase

        // unsigned add/sub family reports the top bit twice
        case (iss.cmd.arith)
            OP_ADD, OP_SUB, OP_ADD_CIN, OP_SUB_CIN: begin
                rsl.flags[F_COUT]  = rsl.res[WIDTH];
                rsl.flags[F_OFLOW] = rsl.res[WIDTH];
            end
            default: ;
        endcase
    end

endmodule

// ==== src/alu_logic_unit.sv ====
`timescale 1ns/10ps

module alu_logic_unit import alu_op_pkg::*; import alu_io_pkg::*; #(
    parameter int WIDTH = 8
) (
    alu_issue_if.exec_mp  iss,
    alu_result_if.unit_mp rsl
);

    localparam int SHW = $clog2(WIDTH);

    logic [SHW-1:0]   amt;      // rotate amount
    logic             amt_big;  // B has bits above the amount field
    logic [WIDTH-1:0] rol;
    logic [WIDTH-1:0] ror;
    logic [WIDTH-1:0] r;

    assign amt     = iss.b[SHW-1:0];
    assign amt_big = |iss.b[WIDTH-1:SHW];

    // amt = 0 shifts by WIDTH on the far side and leaves a unchanged
    assign rol = (iss.a << amt) | (iss.a >> (WIDTH - amt));
    assign ror = (iss.a >> amt) | (iss.a << (WIDTH - amt));

    always_comb begin
        r         = '0;
        rsl.flags = '0;
        case (iss.cmd.lgc)
            OP_AND:    r = iss.a & iss.b;
            OP_NAND:   r = ~(iss.a & iss.b);
            OP_OR:     r = iss.a | iss.b;
            OP_NOR:    r = ~(iss.a | iss.b);
            OP_XOR:    r = iss.a ^ iss.b;
            OP_XNOR:   r = ~(iss.a ^ iss.b);
            OP_NOT_A:  r = ~iss.a;
            OP_NOT_B:  r = ~iss.b;
            OP_SHR1_A: r = iss.a >> 1;
            OP_SHL1_A: r = iss.a << 1;   // top bit drops out
            OP_SHR1_B: r = iss.b >> 1;
            OP_SHL1_B: r = iss.b << 1;
            OP_ROL: begin
                r                = rol;
                rsl.flags[F_ERR] = amt_big;
            end
            OP_ROR: begin
                r                = ror;
                rsl.flags[F_ERR] = amt_big;
            end
            default: ;
        endcase
    end

    assign rsl.res = {1'b0, r};   // logic results never use the extra bit

endmodule

// ==== src/alu_writeback.sv ====
`timescale 1ns/10ps

module alu_writeback import alu_io_pkg::*; #(
    parameter int WIDTH = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              ce,
    alu_issue_if.exec_mp      iss,
    alu_result_if.wb_mp       ar,
    alu_result_if.wb_mp       lg,
    output logic [WIDTH:0]    res,
    output logic [FLAG_W-1:0] flags
);

    localparam logic [FLAG_W-1:0] ERR_ONLY = FLAG_W'(1) << F_ERR;

    logic [WIDTH:0]    sel_res;
    logic [FLAG_W-1:0] sel_flags;

    // bad items collapse to a bare err
    always_comb begin
        if (iss.bad) begin
            sel_res   = '0;
            sel_flags = ERR_ONLY;
        end else if (iss.mode) begin
            sel_res   = ar.res;
            sel_flags = ar.flags;
        end else begin
            sel_res   = lg.res;
            sel_flags = lg.flags;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res   <= '0;
            flags <= '0;
        end else if (ce && iss.valid) begin
            res   <= sel_res;
            flags <= sel_flags;
        end
    end

endmodule

// ==== src/alu_top.sv ====
`timescale 1ns/10ps

module alu_top import alu_op_pkg::*; import alu_io_pkg::*; #(
    parameter int WIDTH = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ce,
    input  logic             mode,
    input  logic             cin,
    input  logic [1:0]       inp_valid,
    input  logic [CMD_W-1:0] cmd,
    input  logic [WIDTH-1:0] opa,
    input  logic [WIDTH-1:0] opb,
    output logic [WIDTH:0]   res,
    output logic             oflow,
    output logic             cout,
    output logic             g,
    output logic             l,
    output logic             e,
    output logic             err,
    output logic             neg,
    output logic             zero
);

    logic [FLAG_W-1:0] flags;

    alu_issue_if  #(.WIDTH(WIDTH)) iss_if ();
    alu_result_if #(.WIDTH(WIDTH)) ar_if ();
    alu_result_if #(.WIDTH(WIDTH)) lg_if ();

    alu_issue #(.WIDTH(WIDTH)) u_issue (
        .clk       (clk),
        .rst       (rst),
        .ce        (ce),
        .mode      (mode),
        .cin       (cin),
        .inp_valid (inp_valid),
        .cmd       (cmd),
        .opa       (opa),
        .opb       (opb),
        .iss       (iss_if.issue_mp)
    );

    alu_arith_unit #(.WIDTH(WIDTH)) u_arith (.iss(iss_if.exec_mp), .rsl(ar_if.unit_mp));
    alu_logic_unit #(.WIDTH(WIDTH)) u_logic (.iss(iss_if.exec_mp), .rsl(lg_if.unit_mp));

    alu_writeback #(.WIDTH(WIDTH)) u_wb (
        .clk   (clk),
        .rst   (rst),
        .ce    (ce),
        .iss   (iss_if.exec_mp),
        .ar    (ar_if.wb_mp),
        .lg    (lg_if.wb_mp),
        .res   (res),
        .flags (flags)
    );

    // named flag outputs
    assign oflow = flags[F_OFLOW];
    assign cout  = flags[F_COUT];
    assign g     = flags[F_G];
    assign l     = flags[F_L];
    assign e     = flags[F_E];
    assign err   = flags[F_ERR];
    assign neg   = flags[F_NEG];
    assign zero  = flags[F_ZERO];

endmodule

// ==== sim/alu_chk.sv ====
`timescale 1ns/10ps

module alu_chk import alu_op_pkg::*; #(
    parameter int WIDTH = 8
) (
    input logic             clk,
    input logic             rst,
    input logic             ce,
    input logic             mode,
    input logic [CMD_W-1:0] cmd,
    input logic [WIDTH:0]   res,
    input logic             oflow,
    input logic             cout,
    input logic             g,
    input logic             l,
    input logic             e,
    input logic             err,
    input logic             neg,
    input logic             zero
);

    logic rot_s1;    // item in issue is a rotate
    logic rot_out;   // item on the outputs is a rotate
    logic cmp_s1;    // item in issue is a compare
    logic cmp_out;
    int   fail_cnt = 0;   // failed assertion count

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rot_s1  <= 1'b0;
            rot_out <= 1'b0;
            cmp_s1  <= 1'b0;
            cmp_out <= 1'b0;
        end else if (ce) begin
            rot_out <= rot_s1;
            rot_s1  <= !mode && (cmd == OP_ROL || cmd == OP_ROR);
            cmp_out <= cmp_s1;
            cmp_s1  <= mode && (cmd == OP_CMP);
        end
    end

    // exactly one of g, l, e on a good compare and none otherwise
    cmp_onehot: assert property (@(posedge clk) disable iff (rst)
        (cmp_out && !err) ? $onehot({g, l, e}) : ({g, l, e} == 3'b000))
        else begin
            $error("g, l, e do not match the item on the outputs");
            fail_cnt++;
        end

    err_res_zero: assert property (@(posedge clk) disable iff (rst)
        err && !rot_out |-> res == '0)
        else begin
            $error("err with nonzero res on a non-rotate item");
            fail_cnt++;
        end

    hold_on_stall: assert property (@(posedge clk) disable iff (rst)
        !ce |=> $stable({res, oflow, cout, g, l, e, err, neg, zero}))
        else begin
            $error("outputs changed while ce was low");
            fail_cnt++;
        end

endmodule

bind alu_top alu_chk #(.WIDTH(WIDTH)) chk0 (.*);

// ==== sim/alu_tb.sv ====
`timescale 1ns/10ps

module alu_tb import alu_op_pkg::*, alu_io_pkg::*; ();

    localparam int W = 8;

    localparam logic [7:0] FL_OV  = 8'd1 << F_OFLOW;
    localparam logic [7:0] FL_CO  = 8'd1 << F_COUT;
    localparam logic [7:0] FL_G   = 8'd1 << F_G;
    localparam logic [7:0] FL_L   = 8'd1 << F_L;
    localparam logic [7:0] FL_E   = 8'd1 << F_E;
    localparam logic [7:0] FL_ERR = 8'd1 << F_ERR;
    localparam logic [7:0] FL_NEG = 8'd1 << F_NEG;
    localparam logic [7:0] FL_Z   = 8'd1 << F_ZERO;

    typedef struct packed {
        logic             mode;
        logic [CMD_W-1:0] cmd;
        logic [1:0]       iv;
        logic [W-1:0]     a;
        logic [W-1:0]     b;
        logic             cin;
        logic             ce;
        logic [W:0]       res;
        logic [7:0]       flags;
    } row_t;

    logic             clk = 1'b0;
    logic             rst, ce, mode, cin;
    logic [1:0]       inp_valid;
    logic [CMD_W-1:0] cmd;
    logic [W-1:0]     opa, opb;
    logic [W:0]       res;
    logic             oflow, cout, g, l, e, err, neg, zero;
    logic [7:0]       flags_act;

    row_t       rows[$];
    logic [7:0] lfsr = 8'd29;
    logic [W:0] exp_res, stg_res;    // model of output and issue stage
    logic [7:0] exp_flags, stg_flags;
    logic       stg_v;

    alu_top #(.WIDTH(W)) dut0 (.*);

    assign flags_act = {zero, neg, err, e, l, g, cout, oflow};   // alu_io_pkg bit order

    always #4 clk = ~clk;

    initial begin
        repeat (5) @(posedge clk);
        #1 rst = 1'b0;
    end

    // taps 8,6,5,4
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic draw_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[6:0], lfsr[0]};
        end
    endtask

    // expected {flags, res} of an arithmetic item
    function automatic logic [8+W:0] arith_ref(input logic [3:0] op, input logic [W-1:0] a,
                                               input logic [W-1:0] b, input logic c);
        int         r;
        int         sa;
        int         sb;
        logic [7:0] f;
        logic [W:0] rr;
        f  = '0;
        r  = 0;
        sa = $signed(a);
        sb = $signed(b);
        case (op)
            OP_ADD:     r = a + b;
            OP_SUB:     r = a - b;
            OP_ADD_CIN: r = a + b + c;
            OP_SUB_CIN: r = a - b - c;
            OP_INC_A:   r = a + 1;
            OP_DEC_A:   r = a - 1;
            OP_INC_B:   r = b + 1;
            OP_DEC_B:   r = b - 1;
            OP_CMP: begin
                if (a > b)
                    f[F_G] = 1'b1;
                else if (a < b)
                    f[F_L] = 1'b1;
                else
                    f[F_E] = 1'b1;
            end
            OP_SADD, OP_SSUB: begin
                r          = (op == OP_SADD) ? sa + sb : sa - sb;
                f[F_OFLOW] = (r > 2**(W-1) - 1) || (r < -(2**(W-1)));
                f[F_COUT]  = (op == OP_SADD) ? (a + b > 2**W - 1) : (a < b);
                f[F_NEG]   = r[W-1];
                f[F_ZERO]  = (r[W-1:0] == 0);
            end
            default: ;
        endcase
        rr = r[W:0];
        if (op == OP_SADD || op == OP_SSUB)
            rr[W] = 1'b0;   // zero-extended
        if (op inside {OP_ADD, OP_SUB, OP_ADD_CIN, OP_SUB_CIN}) begin
            f[F_COUT]  = rr[W];
            f[F_OFLOW] = rr[W];
        end
        return {f, rr};
    endfunction

    task automatic add_row(input logic m, input logic [3:0] op, input logic [1:0] iv,
                           input logic [W-1:0] a, input logic [W-1:0] b, input logic c,
                           input logic en, input logic [W:0] r, input logic [7:0] f);
        rows.push_back('{m, op, iv, a, b, c, en, r, f});
    endtask

    task automatic add_arith(input logic [3:0] op, input logic [1:0] iv,
                             input logic [W-1:0] a, input logic [W-1:0] b, input logic c);
        logic [8+W:0] x;
        x = arith_ref(op, a, b, c);
        add_row(1'b1, op, iv, a, b, c, 1'b1, x[W:0], x[8+W:W+1]);
    endtask

    task automatic build_table();
        logic [7:0] ra;
        logic [7:0] rb;
        logic [7:0] rop;
        logic [7:0] rc;
        logic [1:0] riv;
        // wraparound at both limits
        add_row(1, OP_ADD,     OPS_AB, 8'hFF, 8'h01, 0, 1, 9'h100, FL_CO | FL_OV);
        add_row(1, OP_SUB,     OPS_AB, 8'h00, 8'h01, 0, 1, 9'h1FF, FL_CO | FL_OV);
        add_row(1, OP_ADD_CIN, OPS_AB, 8'hFF, 8'h00, 1, 1, 9'h100, FL_CO | FL_OV);
        add_row(1, OP_SUB_CIN, OPS_AB, 8'h05, 8'h03, 1, 1, 9'h001, 8'h00);
        add_row(1, OP_INC_A,   OPS_A,  8'hFF, 8'h00, 0, 1, 9'h100, 8'h00);
        add_row(1, OP_DEC_A,   OPS_A,  8'h10, 8'h00, 0, 1, 9'h00F, 8'h00);
        add_row(1, OP_INC_B,   OPS_B,  8'h00, 8'h10, 0, 1, 9'h011, 8'h00);
        add_row(1, OP_DEC_B,   OPS_B,  8'h00, 8'h00, 0, 1, 9'h1FF, 8'h00);
        add_row(1, OP_CMP,     OPS_AB, 8'h05, 8'h03, 0, 1, 9'h000, FL_G);
        add_row(1, OP_CMP,     OPS_AB, 8'h03, 8'h05, 0, 1, 9'h000, FL_L);
        add_row(1, OP_CMP,     OPS_AB, 8'h07, 8'h07, 0, 1, 9'h000, FL_E);
        add_row(1, OP_SADD,    OPS_AB, 8'h7F, 8'h01, 0, 1, 9'h080, FL_OV | FL_NEG);
        add_row(1, OP_SADD,    OPS_AB, 8'h80, 8'h80, 0, 1, 9'h000, FL_OV | FL_CO | FL_Z);
        add_row(1, OP_SADD,    OPS_AB, 8'h03, 8'hFE, 0, 1, 9'h001, FL_CO);
        add_row(1, OP_SSUB,    OPS_AB, 8'h80, 8'h01, 0, 1, 9'h07F, FL_OV);
        add_row(1, OP_SSUB,    OPS_AB, 8'h05, 8'h05, 0, 1, 9'h000, FL_Z);
        // logic set on a = A5, b = 3C
        add_row(0, OP_AND,     OPS_AB, 8'hA5, 8'h3C, 0, 1, 9'h024, 8'h00);
        add_row(0, OP_NAND,    OPS_AB, 8'hA5, 8'h3C, 0, 1, 9'h0DB, 8'h00);
        add_row(0, OP_OR,      OPS_AB, 8'hA5, 8'h3C, 0, 1, 9'h0BD, 8'h00);
        add_row(0, OP_NOR,     OPS_AB, 8'hA5, 8'h3C, 0, 1, 9'h042, 8'h00);
        add_row(0, OP_XOR,     OPS_AB, 8'hA5, 8'h3C, 0, 1, 9'h099, 8'h00);
        add_row(0, OP_XNOR,    OPS_AB, 8'hA5, 8'h3C, 0, 1, 9'h066, 8'h00);
        add_row(0, OP_NOT_A,   OPS_A,  8'hA5, 8'h3C, 0, 1, 9'h05A, 8'h00);
        add_row(0, OP_NOT_B,   OPS_B,  8'hA5, 8'h3C, 0, 1, 9'h0C3, 8'h00);
        add_row(0, OP_SHR1_A,  OPS_A,  8'hA5, 8'h3C, 0, 1, 9'h052, 8'h00);
        add_row(0, OP_SHL1_A,  OPS_A,  8'hA5, 8'h3C, 0, 1, 9'h04A, 8'h00);
        add_row(0, OP_SHR1_B,  OPS_B,  8'hA5, 8'h3C, 0, 1, 9'h01E, 8'h00);
        add_row(0, OP_SHL1_B,  OPS_B,  8'hA5, 8'h3C, 0, 1, 9'h078, 8'h00);
        add_row(0, OP_ROL,     OPS_AB, 8'hA5, 8'h00, 0, 1, 9'h0A5, 8'h00);
        add_row(0, OP_ROL,     OPS_AB, 8'hA5, 8'h03, 0, 1, 9'h02D, 8'h00);
        add_row(0, OP_ROR,     OPS_AB, 8'hA5, 8'h03, 0, 1, 9'h0B4, 8'h00);
        add_row(0, OP_ROR,     OPS_AB, 8'hA5, 8'h07, 0, 1, 9'h04B, 8'h00);
        add_row(0, OP_ROL,     OPS_AB, 8'hA5, 8'h08, 0, 1, 9'h0A5, FL_ERR);  // amount too big
        // operand mismatch and undefined opcodes
        add_row(1, OP_ADD,     OPS_A,  8'h11, 8'h22, 0, 1, 9'h000, FL_ERR);
        add_row(1, OP_INC_A,   OPS_AB, 8'h11, 8'h22, 0, 1, 9'h000, FL_ERR);
        add_row(1, 4'd11,      OPS_AB, 8'h11, 8'h22, 0, 1, 9'h000, FL_ERR);
        add_row(1, 4'd15,      OPS_AB, 8'h11, 8'h22, 0, 1, 9'h000, FL_ERR);
        add_row(0, 4'd14,      OPS_AB, 8'h11, 8'h22, 0, 1, 9'h000, FL_ERR);
        add_row(0, OP_NOT_B,   OPS_A,  8'h11, 8'h22, 0, 1, 9'h000, FL_ERR);
        add_row(0, OP_AND,     2'd0,   8'h11, 8'h22, 0, 1, 9'h000, FL_ERR);
        // inputs under ce low are not taken
        add_row(1, OP_ADD,     OPS_AB, 8'h01, 8'h02, 0, 1, 9'h003, 8'h00);
        add_row(1, OP_ADD,     OPS_AB, 8'hFF, 8'hFF, 0, 0, 9'h000, 8'h00);
        add_row(1, OP_ADD,     OPS_AB, 8'hFF, 8'hFF, 0, 0, 9'h000, 8'h00);
        add_row(1, OP_ADD,     OPS_AB, 8'hFF, 8'hFF, 0, 0, 9'h000, 8'h00);
        add_row(1, OP_SUB,     OPS_AB, 8'h09, 8'h04, 0, 1, 9'h005, 8'h00);
        for (int k = 0; k < 24; k++) begin
            draw_bits(8, ra);
            draw_bits(8, rb);
            draw_bits(4, rop);
            draw_bits(1, rc);
            rop = rop % 11;   // 11 arithmetic opcodes
            riv = (rop == OP_INC_A || rop == OP_DEC_A) ? OPS_A :
                  (rop == OP_INC_B || rop == OP_DEC_B) ? OPS_B : OPS_AB;
            add_arith(rop[3:0], riv, ra, rb, rc[0]);
        end
        add_row(0, OP_AND, OPS_AB, 8'h00, 8'h00, 0, 1, 9'h000, 8'h00);   // flush
        add_row(0, OP_AND, OPS_AB, 8'h00, 8'h00, 0, 1, 9'h000, 8'h00);
    endtask

    task automatic drive_row(input row_t r);
        mode      = r.mode;
        cmd       = r.cmd;
        inp_valid = r.iv;
        opa       = r.a;
        opb       = r.b;
        cin       = r.cin;
        ce        = r.ce;
    endtask

    // two-stage pipeline of expected values
    task automatic advance_model(input row_t r);
        if (r.ce) begin
            if (stg_v) begin
                exp_res   = stg_res;
                exp_flags = stg_flags;
            end
            stg_res   = r.res;
            stg_flags = r.flags;
            stg_v     = 1'b1;
        end
    endtask

    task automatic fail_stop();
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_outputs();
        assert (res === exp_res) else begin
            $display("FAIL time=%0t res expected=%h actual=%h", $time, exp_res, res);
            fail_stop();
        end
        assert (flags_act === exp_flags) else begin
            $display("FAIL time=%0t flags expected=%b actual=%b", $time, exp_flags, flags_act);
            fail_stop();
        end
        assert (dut0.chk0.fail_cnt == 0) else begin
            $display("a concurrent assertion in the bound checker failed");
            fail_stop();
        end
    endtask

    initial begin
        int cnt;
        rst       = 1'b1;
        ce        = 1'b0;
        mode      = 1'b0;
        cin       = 1'b0;
        inp_valid = 2'd0;
        cmd       = '0;
        opa       = '0;
        opb       = '0;
        exp_res   = '0;
        exp_flags = '0;
        stg_res   = '0;
        stg_flags = '0;
        stg_v     = 1'b0;
        build_table();
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
        end while (rst && cnt < 20);
        if (rst) begin
            $display("reset was still asserted after 20 cycles");
            fail_stop();
        end
        #1;
        for (int n = 0; n < rows.size(); n++) begin
            check_outputs();
            drive_row(rows[n]);
            @(posedge clk);
            advance_model(rows[n]);
            #1;
        end
        check_outputs();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== files.f ====
src/alu_op_pkg.sv
src/alu_io_pkg.sv
src/alu_stage_if.sv
src/alu_issue.sv
src/alu_arith_unit.sv
src/alu_logic_unit.sv
src/alu_writeback.sv
src/alu_top.sv
sim/alu_chk.sv
sim/alu_tb.sv

// ==== Bender.yml ====
package:
  name: alu_pipe

sources:
  - files:
      - src/alu_op_pkg.sv
      - src/alu_io_pkg.sv
      - src/alu_stage_if.sv
      - src/alu_issue.sv
      - src/alu_arith_unit.sv
      - src/alu_logic_unit.sv
      - src/alu_writeback.sv
      - src/alu_top.sv
  - target: simulation
    files:
      - sim/alu_chk.sv
      - sim/alu_tb.sv
